// File: src/idfp_config.svh
// widths shared by the FP issue stage RTL
// include wherever a width macro is needed; the package pulls it in as well
`ifndef IDFP_CONFIG_SVH
`define IDFP_CONFIG_SVH

// ------------------------------
// register file and data path
// ------------------------------
`define IDFP_REG_IDX_W 5
`define IDFP_DATA_W    32

// ------------------------------
// instruction control fields
// ------------------------------
`define IDFP_FUNC_W    10
`define IDFP_RM_W      3
`define IDFP_UNIT_W    3

// rs1, rs2, rs3
`define IDFP_NUM_SRC   3

`endif

// File: src/idfp_pkg.sv
// shared struct types of the FP issue stage
// referenced by scoped name from every RTL module
`include "idfp_config.svh"

package idfp_pkg;

  // one decoded source operand reference
  typedef struct packed {
    logic                       valid;
    logic [`IDFP_REG_IDX_W-1:0] idx;
  } src_ref_t;

  // result bus, used for fpu, lsu ex2/ex3 forwards and writeback
  typedef struct packed {
    logic                       valid;
    logic [`IDFP_REG_IDX_W-1:0] idx;
    logic [`IDFP_DATA_W-1:0]    data;
  } fwd_bus_t;

  // register file read port view of one source
  typedef struct packed {
    logic [`IDFP_DATA_W-1:0] data;
    logic                    busy;
    logic                    busy_lsu;
  } fpr_read_t;

  // decoded instruction sitting in ID
  // load = lsu_sel & dst_vld, store = lsu_sel & ~dst_vld
  typedef struct packed {
    logic                                valid;
    logic                                lsu_sel;
    logic                                dst_vld;
    logic [`IDFP_REG_IDX_W-1:0]          dst_idx;
    src_ref_t [`IDFP_NUM_SRC-1:0]        src;
    logic [`IDFP_UNIT_W-1:0]             unit_sel;
    logic [`IDFP_FUNC_W-1:0]             func;
    logic [`IDFP_RM_W-1:0]               rm;
    logic                                expt;
  } id_inst_t;

  // per-source hit flags, bit i belongs to source i
  typedef struct packed {
    logic [`IDFP_NUM_SRC-1:0] fpu;
    logic [`IDFP_NUM_SRC-1:0] ex2;
    logic [`IDFP_NUM_SRC-1:0] ex3;
  } fwd_hit_t;

  // EX1 view handed to the FPU
  typedef struct packed {
    logic [`IDFP_UNIT_W-1:0]    unit_sel;
    logic [`IDFP_FUNC_W-1:0]    func;
    logic [`IDFP_RM_W-1:0]      rm;
    logic                       dst_vld;
    logic [`IDFP_REG_IDX_W-1:0] dst_idx;
    logic [`IDFP_DATA_W-1:0]    srcf0;
    logic [`IDFP_DATA_W-1:0]    srcf1;
    logic [`IDFP_DATA_W-1:0]    srcf2;
  } ex1_inst_t;

endpackage

// File: src/idfp_operand_fwd.sv
// operand bypass for the FP issue stage
// picks each source from lsu ex3, fpu, lsu ex2 or the register file
`timescale 1ns/1ps
`include "idfp_config.svh"

module idfp_operand_fwd (
  input  idfp_pkg::src_ref_t  [`IDFP_NUM_SRC-1:0]                   srcs,
  input  idfp_pkg::fpr_read_t [`IDFP_NUM_SRC-1:0]                   fpr_src,
  input  idfp_pkg::fwd_bus_t                                        fpu_fwd,
  input  idfp_pkg::fwd_bus_t                                        lsu_ex2_fwd,
  input  idfp_pkg::fwd_bus_t                                        lsu_ex3_fwd,
  output logic                [`IDFP_NUM_SRC-1:0][`IDFP_DATA_W-1:0] operand,
  output idfp_pkg::fwd_hit_t                                        hits
);

  // source hits a bus only when both sides are valid and the index matches
  function automatic logic bus_hit(
    input idfp_pkg::src_ref_t src,
    input idfp_pkg::fwd_bus_t bus
  );
    bus_hit = src.valid & bus.valid & (src.idx == bus.idx);
  endfunction

  logic [`IDFP_NUM_SRC-1:0] hit_fpu;
  logic [`IDFP_NUM_SRC-1:0] hit_ex2;
  logic [`IDFP_NUM_SRC-1:0] hit_ex3;

  // ------------------------------
  // hit detection
  // ------------------------------
  always_comb
  begin
    for (int i = 0; i < `IDFP_NUM_SRC; i++)
    begin
      hit_fpu[i] = bus_hit(srcs[i], fpu_fwd);
      hit_ex2[i] = bus_hit(srcs[i], lsu_ex2_fwd);
      hit_ex3[i] = bus_hit(srcs[i], lsu_ex3_fwd);
    end
  end

  assign hits.fpu = hit_fpu;
  assign hits.ex2 = hit_ex2;
  assign hits.ex3 = hit_ex3;

  // ------------------------------
  // operand select
  // ------------------------------
  // ex3 is the youngest load result, so it wins over the fpu bus;
  // ex2 only counts when nothing newer covers the source
  always_comb
  begin
    for (int i = 0; i < `IDFP_NUM_SRC; i++)
    begin
      if (hit_ex3[i])
      begin
        operand[i] = lsu_ex3_fwd.data;
      end
      else if (hit_fpu[i])
      begin
        operand[i] = fpu_fwd.data;
      end
      else if (hit_ex2[i])
      begin
        operand[i] = lsu_ex2_fwd.data;
      end
      else
      begin
        // writeback bypass is already folded into the register file read
        operand[i] = fpr_src[i].data;
      end
    end
  end

endmodule

// File: src/idfp_issue_ctrl.sv
// issue control for the FP issue stage
// dependency stalls, store rs2 dependency and the issue grant, all combinational
`timescale 1ns/1ps
`include "idfp_config.svh"

module idfp_issue_ctrl (
  input  idfp_pkg::id_inst_t                     id_inst,
  input  idfp_pkg::fpr_read_t [`IDFP_NUM_SRC-1:0] fpr_src,
  input  logic                                   fpr_rd_busy,
  input  logic                                   fpr_rd_busy_lsu,
  input  idfp_pkg::fwd_hit_t                     hits,
  input  logic                                   ex1_vld,
  input  logic                                   ex1_lsu_load,
  input  logic [`IDFP_REG_IDX_W-1:0]             ex1_dst,
  input  logic                                   flush,
  input  logic                                   ex1_hold,
  output logic                                   issue,
  output logic                                   id_stall,
  output logic                                   st_rs2_dep,
  output logic                                   fpr_wr_issue
);

  // rs2 sits in source slot 1
  localparam int RS2 = 1;

  logic [`IDFP_NUM_SRC-1:0] src_busy;
  logic [`IDFP_NUM_SRC-1:0] src_busy_lsu;
  logic                     id_st_inst;
  logic                     norm_stall;
  logic                     ld_stall;
  logic                     rs2_busy_unres;
  logic                     rs2_dep_ex1;

  // ------------------------------
  // busy vectors
  // ------------------------------
  always_comb
  begin
    for (int i = 0; i < `IDFP_NUM_SRC; i++)
    begin
      src_busy[i]     = fpr_src[i].busy;
      src_busy_lsu[i] = fpr_src[i].busy_lsu;
    end
  end

  // store carries its data in rs2 and has no destination
  assign id_st_inst = id_inst.lsu_sel & ~id_inst.dst_vld;

  // ------------------------------
  // dependency stalls
  // ------------------------------
  // fpu results are only visible on the fpu bus
  assign norm_stall = (|(src_busy & ~hits.fpu) | fpr_rd_busy)
                    & id_inst.valid
                    & ~id_st_inst;

  // load results show up on ex2 or ex3
  assign ld_stall = (|(src_busy_lsu & ~hits.ex2 & ~hits.ex3) | fpr_rd_busy_lsu)
                  & id_inst.valid
                  & ~id_st_inst;

  assign id_stall = norm_stall | ld_stall;

  // ------------------------------
  // store rs2 dependency
  // ------------------------------
  assign rs2_busy_unres = src_busy[RS2] & ~hits.fpu[RS2]
                        | src_busy_lsu[RS2] & ~hits.ex2[RS2] & ~hits.ex3[RS2];

  // load in EX1 that writes the store data register
  assign rs2_dep_ex1 = id_inst.src[RS2].valid
                     & (id_inst.src[RS2].idx == ex1_dst)
                     & ex1_vld
                     & ex1_lsu_load;

  // store still issues; EX1 picks up the data later
  assign st_rs2_dep = (rs2_busy_unres | rs2_dep_ex1)
                    & id_inst.valid
                    & id_st_inst;

  // ------------------------------
  // issue grant
  // ------------------------------
  assign issue = id_inst.valid & ~id_stall & ~ex1_hold & ~flush;

  // reserve the destination in the register file scoreboard
  assign fpr_wr_issue = issue & id_inst.dst_vld;

endmodule

// File: src/idfp_ex1_stage.sv
// EX1 pipeline register of the FP issue stage
// loads on issue, holds under ex1_hold and refreshes store data late
`timescale 1ns/1ps
`include "idfp_config.svh"

module idfp_ex1_stage (
  input  logic                                         idfp_cpuclk,
  input  logic                                         reset,
  input  logic                                         issue,
  input  logic                                         ex1_hold,
  input  idfp_pkg::id_inst_t                           id_inst,
  input  logic [`IDFP_NUM_SRC-1:0][`IDFP_DATA_W-1:0]   operand,
  input  logic                                         st_data_wait,
  input  idfp_pkg::fwd_bus_t                           fpu_fwd,
  input  idfp_pkg::fwd_bus_t                           wb_bus,
  input  idfp_pkg::fwd_bus_t                           lsu_ex2_fwd,
  output logic                                         ex1_vld,
  output idfp_pkg::ex1_inst_t                          ex1,
  output logic                                         ex1_lsu_load,
  output logic [`IDFP_REG_IDX_W-1:0]                   ex1_dst
);

  logic [`IDFP_REG_IDX_W-1:0] ex1_rs2_idx;
  logic                       ex1_lsu_sel;
  logic                       ex1_store;
  logic                       upd_fpu;
  logic                       upd_wb;
  logic                       upd_ex2;
  logic                       st_refresh;
  logic [`IDFP_DATA_W-1:0]    st_refresh_data;

  // ------------------------------
  // valid
  // ------------------------------
  always_ff @(posedge idfp_cpuclk)
  begin
    if (reset)
    begin
      ex1_vld <= 1'b0;
    end
    else if (issue)
    begin
      ex1_vld <= 1'b1;
    end
    else if (!ex1_hold)
    begin
      ex1_vld <= 1'b0;
    end
  end

  // ------------------------------
  // store data refresh
  // ------------------------------
  assign ex1_store = ex1_lsu_sel & ~ex1.dst_vld;

  assign upd_fpu = fpu_fwd.valid & (fpu_fwd.idx == ex1_rs2_idx);
  assign upd_wb  = wb_bus.valid & (wb_bus.idx == ex1_rs2_idx);
  assign upd_ex2 = lsu_ex2_fwd.valid & (lsu_ex2_fwd.idx == ex1_rs2_idx);

  assign st_refresh = ex1_vld & st_data_wait & ex1_store & (upd_fpu | upd_wb | upd_ex2);

  // fpu first, then writeback, ex2 last
  assign st_refresh_data = upd_fpu ? fpu_fwd.data
                         : upd_wb  ? wb_bus.data
                         :           lsu_ex2_fwd.data;

  // ------------------------------
  // payload
  // ------------------------------
  always_ff @(posedge idfp_cpuclk)
  begin
    if (issue)
    begin
      // an excepting instruction must not start any execution unit
      ex1.unit_sel <= id_inst.expt ? '0 : id_inst.unit_sel;
      ex1.func     <= id_inst.func;
      ex1.rm       <= id_inst.rm;
      ex1.dst_vld  <= id_inst.dst_vld;
      ex1.dst_idx  <= id_inst.dst_idx;
      ex1.srcf0    <= operand[0];
      ex1.srcf2    <= operand[2];
      ex1_rs2_idx  <= id_inst.src[1].idx;
      ex1_lsu_sel  <= id_inst.lsu_sel;
    end
  end

  // srcf1 is kept apart since the store refresh also writes it
  always_ff @(posedge idfp_cpuclk)
  begin
    if (issue)
    begin
      ex1.srcf1 <= operand[1];
    end
    else if (st_refresh)
    begin
      ex1.srcf1 <= st_refresh_data;
    end
  end

  // load in EX1, for the store rs2 check in ID
  assign ex1_lsu_load = ex1_lsu_sel & ex1.dst_vld;
  assign ex1_dst      = ex1.dst_idx;

endmodule

// File: src/idfp_top.sv
// top level of the FP issue stage
// operand bypass, issue control and the EX1 register feeding the FPU
`timescale 1ns/1ps
`include "idfp_config.svh"

module idfp_top (
  input  logic                                   idfp_cpuclk,
  input  logic                                   reset,
  input  idfp_pkg::id_inst_t                     id_inst,
  input  idfp_pkg::fpr_read_t [`IDFP_NUM_SRC-1:0] fpr_src,
  input  logic                                   fpr_rd_busy,
  input  logic                                   fpr_rd_busy_lsu,
  input  idfp_pkg::fwd_bus_t                     fpu_fwd,
  input  idfp_pkg::fwd_bus_t                     lsu_ex2_fwd,
  input  idfp_pkg::fwd_bus_t                     lsu_ex3_fwd,
  input  idfp_pkg::fwd_bus_t                     wb_bus,
  input  logic                                   flush,
  input  logic                                   ex1_hold,
  input  logic                                   st_data_wait,
  output logic                                   issue,
  output logic                                   id_stall,
  output logic                                   st_rs2_dep,
  output logic                                   fpr_wr_issue,
  output logic                                   ex1_vld,
  output idfp_pkg::ex1_inst_t                    ex1
);

  logic [`IDFP_NUM_SRC-1:0][`IDFP_DATA_W-1:0] operand;
  idfp_pkg::fwd_hit_t                         hits;
  logic                                       ex1_lsu_load;
  logic [`IDFP_REG_IDX_W-1:0]                 ex1_dst;

  // ------------------------------
  // ID stage
  // ------------------------------
  idfp_operand_fwd operand_fwd_i (
    .srcs        (id_inst.src),
    .fpr_src     (fpr_src),
    .fpu_fwd     (fpu_fwd),
    .lsu_ex2_fwd (lsu_ex2_fwd),
    .lsu_ex3_fwd (lsu_ex3_fwd),
    .operand     (operand),
    .hits        (hits)
  );

  idfp_issue_ctrl issue_ctrl_i (
    .id_inst         (id_inst),
    .fpr_src         (fpr_src),
    .fpr_rd_busy     (fpr_rd_busy),
    .fpr_rd_busy_lsu (fpr_rd_busy_lsu),
    .hits            (hits),
    .ex1_vld         (ex1_vld),
    .ex1_lsu_load    (ex1_lsu_load),
    .ex1_dst         (ex1_dst),
    .flush           (flush),
    .ex1_hold        (ex1_hold),
    .issue           (issue),
    .id_stall        (id_stall),
    .st_rs2_dep      (st_rs2_dep),
    .fpr_wr_issue    (fpr_wr_issue)
  );

  // ------------------------------
  // EX1 stage
  // ------------------------------
  idfp_ex1_stage ex1_stage_i (
    .idfp_cpuclk  (idfp_cpuclk),
    .reset        (reset),
    .issue        (issue),
    .ex1_hold     (ex1_hold),
    .id_inst      (id_inst),
    .operand      (operand),
    .st_data_wait (st_data_wait),
    .fpu_fwd      (fpu_fwd),
    .wb_bus       (wb_bus),
    .lsu_ex2_fwd  (lsu_ex2_fwd),
    .ex1_vld      (ex1_vld),
    .ex1          (ex1),
    .ex1_lsu_load (ex1_lsu_load),
    .ex1_dst      (ex1_dst)
  );

endmodule

// File: tb/idfp_tb_ref.svh
// reference model of the FP issue rules and the typed compare tasks
// included inside the testbench module, after the abort task
`ifndef IDFP_TB_REF_SVH
`define IDFP_TB_REF_SVH

// ------------------------------
// reference functions
// ------------------------------
function automatic logic src_on_bus(input idfp_pkg::src_ref_t s, input idfp_pkg::fwd_bus_t b);
  return s.valid && b.valid && (s.idx == b.idx);
endfunction

// freshest value, ex3 > fpu > ex2 > register file
function automatic logic [`IDFP_DATA_W-1:0] ref_operand(
  input idfp_pkg::src_ref_t  s,
  input idfp_pkg::fpr_read_t r,
  input idfp_pkg::fwd_bus_t  fpu,
  input idfp_pkg::fwd_bus_t  ex2,
  input idfp_pkg::fwd_bus_t  ex3
);
  if (src_on_bus(s, ex3))
    return ex3.data;
  if (src_on_bus(s, fpu))
    return fpu.data;
  if (src_on_bus(s, ex2))
    return ex2.data;
  return r.data;
endfunction

function automatic logic ref_stall(
  input idfp_pkg::id_inst_t                      inst,
  input idfp_pkg::fpr_read_t [`IDFP_NUM_SRC-1:0] fpr,
  input logic                                    rd_busy,
  input logic                                    rd_busy_lsu,
  input idfp_pkg::fwd_bus_t                      fpu,
  input idfp_pkg::fwd_bus_t                      ex2,
  input idfp_pkg::fwd_bus_t                      ex3
);
  logic waiting;
  waiting = rd_busy || rd_busy_lsu;
  for (int i = 0; i < `IDFP_NUM_SRC; i++)
  begin
    if (fpr[i].busy && !src_on_bus(inst.src[i], fpu))
      waiting = 1'b1;
    if (fpr[i].busy_lsu && !src_on_bus(inst.src[i], ex2) && !src_on_bus(inst.src[i], ex3))
      waiting = 1'b1;
  end
  // stores never stall in ID
  return inst.valid && !(inst.lsu_sel && !inst.dst_vld) && waiting;
endfunction

function automatic logic ref_issue(
  input idfp_pkg::id_inst_t inst,
  input logic               stall,
  input logic               hold,
  input logic               flush_in
);
  return inst.valid && !stall && !hold && !flush_in;
endfunction

function automatic logic ref_st_dep(
  input idfp_pkg::id_inst_t                      inst,
  input idfp_pkg::fpr_read_t [`IDFP_NUM_SRC-1:0] fpr,
  input idfp_pkg::fwd_bus_t                      fpu,
  input idfp_pkg::fwd_bus_t                      ex2,
  input idfp_pkg::fwd_bus_t                      ex3,
  input logic                                    e_vld,
  input logic                                    e_load,
  input logic [`IDFP_REG_IDX_W-1:0]              e_dst
);
  logic open;
  open = (fpr[1].busy && !src_on_bus(inst.src[1], fpu))
      || (fpr[1].busy_lsu && !src_on_bus(inst.src[1], ex2) && !src_on_bus(inst.src[1], ex3));
  if (e_vld && e_load && inst.src[1].valid && (inst.src[1].idx == e_dst))
    open = 1'b1;
  return inst.valid && inst.lsu_sel && !inst.dst_vld && open;
endfunction

// store data in EX1, fpu > writeback > ex2, else unchanged
function automatic logic [`IDFP_DATA_W-1:0] ref_store_data(
  input logic [`IDFP_DATA_W-1:0]    cur,
  input logic [`IDFP_REG_IDX_W-1:0] rs2,
  input idfp_pkg::fwd_bus_t         fpu,
  input idfp_pkg::fwd_bus_t         wb,
  input idfp_pkg::fwd_bus_t         ex2
);
  if (fpu.valid && fpu.idx == rs2)
    return fpu.data;
  if (wb.valid && wb.idx == rs2)
    return wb.data;
  if (ex2.valid && ex2.idx == rs2)
    return ex2.data;
  return cur;
endfunction

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
  begin
    $display("CHECK FAILED time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
    abort_run();
  end
endtask

task automatic check_word(
  input string                   name,
  input logic [`IDFP_DATA_W-1:0] got,
  input logic [`IDFP_DATA_W-1:0] exp
);
  if (got !== exp)
  begin
    $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    abort_run();
  end
endtask

task automatic check_ex1(
  input string               name,
  input idfp_pkg::ex1_inst_t got,
  input idfp_pkg::ex1_inst_t exp
);
  check_word({name, ".srcf0"}, got.srcf0, exp.srcf0);
  check_word({name, ".srcf1"}, got.srcf1, exp.srcf1);
  check_word({name, ".srcf2"}, got.srcf2, exp.srcf2);
  if (got !== exp)
  begin
    $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    abort_run();
  end
endtask

`endif

// File: tb/idfp_tb.sv
// testbench for the FP issue stage top level
// weighted random phases, every cycle checked against the reference model
`timescale 1ns/1ps
`include "idfp_config.svh"

module idfp_tb;

  localparam int CLK_PERIOD  = 4;
  localparam int RESET_CYC   = 10;
  localparam int PHASE_CYC   = 300;
  localparam int NUM_PHASES  = 4;
  localparam int TEST_CYCLES = RESET_CYC + NUM_PHASES * PHASE_CYC + 20;

  // stimulus phases
  localparam int MODE_FREE  = 0;
  localparam int MODE_BUSY  = 1;
  localparam int MODE_STORE = 2;
  localparam int MODE_CTRL  = 3;

  logic                                   idfp_cpuclk;
  logic                                   reset;
  idfp_pkg::id_inst_t                     id_inst;
  idfp_pkg::fpr_read_t [`IDFP_NUM_SRC-1:0] fpr_src;
  logic                                   fpr_rd_busy;
  logic                                   fpr_rd_busy_lsu;
  idfp_pkg::fwd_bus_t                     fpu_fwd;
  idfp_pkg::fwd_bus_t                     lsu_ex2_fwd;
  idfp_pkg::fwd_bus_t                     lsu_ex3_fwd;
  idfp_pkg::fwd_bus_t                     wb_bus;
  logic                                   flush;
  logic                                   ex1_hold;
  logic                                   st_data_wait;
  logic                                   issue;
  logic                                   id_stall;
  logic                                   st_rs2_dep;
  logic                                   fpr_wr_issue;
  logic                                   ex1_vld;
  idfp_pkg::ex1_inst_t                    ex1;

  integer                     seed;
  // expected EX1 state
  logic                       exp_vld;
  idfp_pkg::ex1_inst_t        exp_ex1;
  logic [`IDFP_REG_IDX_W-1:0] exp_rs2_idx;
  logic                       exp_lsu_sel;
  int                         n_issue;
  int                         n_stall;
  int                         n_dep;
  int                         n_refresh;
  int                         n_expt;

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  `include "idfp_tb_ref.svh"

  idfp_top dut_i (
    .idfp_cpuclk     (idfp_cpuclk),
    .reset           (reset),
    .id_inst         (id_inst),
    .fpr_src         (fpr_src),
    .fpr_rd_busy     (fpr_rd_busy),
    .fpr_rd_busy_lsu (fpr_rd_busy_lsu),
    .fpu_fwd         (fpu_fwd),
    .lsu_ex2_fwd     (lsu_ex2_fwd),
    .lsu_ex3_fwd     (lsu_ex3_fwd),
    .wb_bus          (wb_bus),
    .flush           (flush),
    .ex1_hold        (ex1_hold),
    .st_data_wait    (st_data_wait),
    .issue           (issue),
    .id_stall        (id_stall),
    .st_rs2_dep      (st_rs2_dep),
    .fpr_wr_issue    (fpr_wr_issue),
    .ex1_vld         (ex1_vld),
    .ex1             (ex1)
  );

  initial
  begin
    idfp_cpuclk = 1'b0;
    forever #(CLK_PERIOD / 2) idfp_cpuclk = ~idfp_cpuclk;
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  function automatic int roll(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // indices kept in 0..3 so buses and sources collide often
  function automatic idfp_pkg::fwd_bus_t rand_bus();
    idfp_pkg::fwd_bus_t b;
    b.valid = roll(2) != 0;
    b.idx   = roll(4);
    b.data  = $random(seed);
    return b;
  endfunction

  task automatic drive_idle();
    id_inst         <= '0;
    fpr_src         <= '0;
    fpr_rd_busy     <= 1'b0;
    fpr_rd_busy_lsu <= 1'b0;
    fpu_fwd         <= '0;
    lsu_ex2_fwd     <= '0;
    lsu_ex3_fwd     <= '0;
    wb_bus          <= '0;
    flush           <= 1'b0;
    ex1_hold        <= 1'b0;
    st_data_wait    <= 1'b0;
  endtask

  task automatic drive_inputs(input int mode);
    idfp_pkg::id_inst_t                      inst;
    idfp_pkg::fpr_read_t [`IDFP_NUM_SRC-1:0] rd;
    inst.valid   = roll(8) != 0;
    inst.lsu_sel = (mode == MODE_STORE) ? (roll(4) != 0) : (roll(4) == 0);
    inst.dst_vld = (mode == MODE_STORE) ? (roll(2) != 0) : (roll(4) != 0);
    inst.dst_idx = roll(4);
    for (int i = 0; i < `IDFP_NUM_SRC; i++)
    begin
      inst.src[i].valid = roll(4) != 0;
      inst.src[i].idx   = roll(4);
      rd[i].data        = $random(seed);
      rd[i].busy        = (mode != MODE_FREE) && (roll(3) == 0);
      rd[i].busy_lsu    = (mode != MODE_FREE) && (roll(3) == 0);
    end
    inst.unit_sel = roll(8);
    inst.func     = $random(seed);
    inst.rm       = roll(8);
    inst.expt     = (mode == MODE_CTRL) && (roll(3) == 0);
    id_inst         <= inst;
    fpr_src         <= rd;
    fpr_rd_busy     <= (mode == MODE_BUSY) && (roll(10) == 0);
    fpr_rd_busy_lsu <= (mode == MODE_BUSY) && (roll(10) == 0);
    fpu_fwd         <= rand_bus();
    lsu_ex2_fwd     <= rand_bus();
    lsu_ex3_fwd     <= rand_bus();
    wb_bus          <= rand_bus();
    flush           <= (mode == MODE_CTRL) && (roll(4) == 0);
    ex1_hold        <= (mode >= MODE_STORE) && (roll(3) == 0);
    st_data_wait    <= (mode == MODE_STORE) && (roll(2) == 0);
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial
  begin
    seed = 32'hf88e;
    reset <= 1'b1;
    drive_idle();
    repeat (RESET_CYC) @(posedge idfp_cpuclk);
    reset <= 1'b0;
    for (int m = 0; m < NUM_PHASES; m++)
    begin
      repeat (PHASE_CYC)
      begin
        @(posedge idfp_cpuclk);
        drive_inputs(m);
      end
    end
    // reset again with traffic in ID, EX1 must come up empty
    repeat (3)
    begin
      @(posedge idfp_cpuclk);
      reset <= 1'b1;
      drive_inputs(MODE_FREE);
    end
    @(posedge idfp_cpuclk);
    reset <= 1'b0;
    drive_idle();
    repeat (10) @(posedge idfp_cpuclk);
    @(negedge idfp_cpuclk);
    if (n_issue == 0 || n_stall == 0 || n_dep == 0 || n_refresh == 0 || n_expt == 0)
    begin
      $display("stimulus missed a behavior: issue %0d stall %0d dep %0d refresh %0d expt %0d",
               n_issue, n_stall, n_dep, n_refresh, n_expt);
      abort_run();
    end
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

  // ------------------------------
  // compare at the falling edge
  // ------------------------------
  initial
  begin : compare_loop
    logic exp_stall;
    logic exp_issue;
    logic exp_dep;
    logic [`IDFP_DATA_W-1:0] new_srcf1;
    exp_vld     = 1'b0;
    exp_ex1     = '0;
    exp_rs2_idx = '0;
    exp_lsu_sel = 1'b0;
    n_issue     = 0;
    n_stall     = 0;
    n_dep       = 0;
    n_refresh   = 0;
    n_expt      = 0;
    @(posedge idfp_cpuclk);
    forever
    begin
      @(negedge idfp_cpuclk);
      check_bit("ex1_vld", ex1_vld, exp_vld);
      if (exp_vld)
        check_ex1("ex1", ex1, exp_ex1);
      exp_stall = ref_stall(id_inst, fpr_src, fpr_rd_busy, fpr_rd_busy_lsu,
                            fpu_fwd, lsu_ex2_fwd, lsu_ex3_fwd);
      exp_issue = ref_issue(id_inst, exp_stall, ex1_hold, flush);
      exp_dep   = ref_st_dep(id_inst, fpr_src, fpu_fwd, lsu_ex2_fwd, lsu_ex3_fwd,
                             exp_vld, exp_lsu_sel & exp_ex1.dst_vld, exp_ex1.dst_idx);
      check_bit("id_stall", id_stall, exp_stall);
      check_bit("issue", issue, exp_issue);
      check_bit("fpr_wr_issue", fpr_wr_issue, exp_issue & id_inst.dst_vld);
      check_bit("st_rs2_dep", st_rs2_dep, exp_dep);
      n_issue += exp_issue;
      n_stall += exp_stall;
      n_dep   += exp_dep;
      // next EX1 state
      if (exp_issue)
      begin
        n_expt += id_inst.expt;
        exp_ex1.unit_sel = id_inst.expt ? '0 : id_inst.unit_sel;
        exp_ex1.func     = id_inst.func;
        exp_ex1.rm       = id_inst.rm;
        exp_ex1.dst_vld  = id_inst.dst_vld;
        exp_ex1.dst_idx  = id_inst.dst_idx;
        exp_ex1.srcf0 = ref_operand(id_inst.src[0], fpr_src[0], fpu_fwd, lsu_ex2_fwd, lsu_ex3_fwd);
        exp_ex1.srcf1 = ref_operand(id_inst.src[1], fpr_src[1], fpu_fwd, lsu_ex2_fwd, lsu_ex3_fwd);
        exp_ex1.srcf2 = ref_operand(id_inst.src[2], fpr_src[2], fpu_fwd, lsu_ex2_fwd, lsu_ex3_fwd);
        exp_rs2_idx = id_inst.src[1].idx;
        exp_lsu_sel = id_inst.lsu_sel;
      end
      else if (exp_vld && st_data_wait && exp_lsu_sel && !exp_ex1.dst_vld)
      begin
        new_srcf1 = ref_store_data(exp_ex1.srcf1, exp_rs2_idx, fpu_fwd, wb_bus, lsu_ex2_fwd);
        if (new_srcf1 !== exp_ex1.srcf1)
          n_refresh++;
        exp_ex1.srcf1 = new_srcf1;
      end
      if (reset)
        exp_vld = 1'b0;
      else if (exp_issue)
        exp_vld = 1'b1;
      else if (!ex1_hold)
        exp_vld = 1'b0;
    end
  end

  // watchdog
  initial
  begin
    #((TEST_CYCLES + 200) * CLK_PERIOD);
    $display("watchdog expired: the tests did not finish within %0d cycles", TEST_CYCLES + 200);
    abort_run();
  end

endmodule

// File: vlog.f
+incdir+src
+incdir+tb
src/idfp_pkg.sv
src/idfp_operand_fwd.sv
src/idfp_issue_ctrl.sv
src/idfp_ex1_stage.sv
src/idfp_top.sv
tb/idfp_tb.sv
